/* hw/cpuPkg.sv */
// word and index types, instruction fields, control enums, datapath and Wishbone structs
package cpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] regIdx_t;
	typedef logic [3:0] flags_t; // {Z, N, C, V}

	// instruction field positions within IR
	localparam int OpcodeLsb = 11;
	localparam int RdLsb = 8;
	localparam int RaLsb = 5;
	localparam int RbLsb = 2;
	localparam int Imm5Msb = 4;
	localparam int Imm8Msb = 7;

	// bit positions in flags_t
	localparam int FlagZ = 3;
	localparam int FlagN = 2;
	localparam int FlagC = 1;
	localparam int FlagV = 0;

	typedef enum logic [4:0] {
		OpAdd  = 5'd0,
		OpAdc  = 5'd1,
		OpSub  = 5'd2,
		OpAnd  = 5'd3,
		OpOr   = 5'd4,
		OpXor  = 5'd5,
		OpAddi = 5'd6,
		OpMovi = 5'd7,
		OpLdw  = 5'd8,
		OpStw  = 5'd9,
		OpBz   = 5'd10,
		OpCall = 5'd11,
		OpRet  = 5'd12,
		OpHalt = 5'd13
	} opcode_t;

	typedef enum logic [2:0] {AluAdd, AluAdc, AluSub, AluAnd, AluOr, AluXor, AluPassB} aluFunc_t;

	typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Rd2, Op2Imm, Op2One} op2Sel_t;
	typedef enum logic {ImmShort, ImmLong} immSel_t; // imm5 or imm8
	typedef enum logic [1:0] {WdAlu, WdMem, WdLr} wdSel_t;
	typedef enum logic [1:0] {PcInc, PcAluOut, PcLr, PcBranch} pcSel_t;
	typedef enum logic {AdrPc, AdrAluOut} adrSel_t;

	typedef enum logic [2:0] {SFetch, SDecode, SExec, SMem, SWrite, SHalt} seqState_t;

	// sequencer to datapath
	typedef struct packed {
		aluFunc_t aluOp;
		op1Sel_t op1Sel;
		op2Sel_t op2Sel;
		immSel_t immSel;
		wdSel_t wdSel;
		pcSel_t pcSel;
		adrSel_t adrSel;
		logic pcWe;
		logic lrWe;
		logic irWe;
		logic aluWe;
		logic mdrWe;
		logic regWe;
	} dpCtrl_t;

	// datapath back to sequencer
	typedef struct packed {
		opcode_t opcode;
		flags_t aluFlags;
	} dpStat_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		word_t adr;
		word_t datOut;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		word_t datIn;
	} wbRsp_t;

endpackage

/* hw/regFile.sv */
// register file, eight 16-bit registers, two read ports and one write port
`timescale 1ns/1ps

module regFile (
	input logic Clock,
	input logic rstN,
	input cpuPkg::regIdx_t rs1,
	input cpuPkg::regIdx_t rs2,
	input cpuPkg::regIdx_t rw,
	input cpuPkg::word_t wData,
	input logic we,
	output cpuPkg::word_t rd1,
	output cpuPkg::word_t rd2
);

	cpuPkg::word_t regs [0:7];

	// r0 is cleared by reset and never written, so it always reads zero
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rw != 3'd0)) begin
			regs[rw] <= wData;
		end
	end

	assign rd1 = regs[rs1]; // ra, or unused for MOVI
	assign rd2 = regs[rs2]; // rb, or rd for stores

endmodule

/* hw/alu.sv */
// combinational 16-bit ALU with add, carry add, subtract, logic ops and pass, plus ZNCV flags
`timescale 1ns/1ps

module alu (
	input cpuPkg::word_t op1,
	input cpuPkg::word_t op2,
	input logic carryIn,
	input cpuPkg::aluFunc_t aluOp,
	output cpuPkg::word_t result,
	output cpuPkg::flags_t flags
);

	cpuPkg::word_t opB;
	logic cin;
	logic [16:0] sum;
	logic arith;

	// one adder serves add, adc and sub
	always_comb begin
		if (aluOp == cpuPkg::AluSub) begin
			opB = ~op2;
		end else begin
			opB = op2;
		end
		case (aluOp)
			cpuPkg::AluAdc: cin = carryIn;
			cpuPkg::AluSub: cin = 1'b1; // two's complement
			default: cin = 1'b0;
		endcase
	end

	assign sum = {1'b0, op1} + {1'b0, opB} + {16'd0, cin};

	always_comb begin
		arith = 1'b0;
		case (aluOp)
			cpuPkg::AluAdd, cpuPkg::AluAdc, cpuPkg::AluSub: begin
				result = sum[15:0];
				arith = 1'b1;
			end
			cpuPkg::AluAnd: result = op1 & op2;
			cpuPkg::AluOr: result = op1 | op2;
			cpuPkg::AluXor: result = op1 ^ op2;
			cpuPkg::AluPassB: result = op2; // MOVI
			default: result = '0;
		endcase
	end

	// sub carry comes out as not-borrow
	// overflow when both adder inputs agree in sign and the result does not
	always_comb begin
		flags[cpuPkg::FlagZ] = (result == '0);
		flags[cpuPkg::FlagN] = result[15];
		flags[cpuPkg::FlagC] = arith & sum[16];
		flags[cpuPkg::FlagV] = arith & (op1[15] == opB[15]) & (result[15] != op1[15]);
	end

endmodule

/* hw/datapath.sv */
// datapath with PC, LR, IR, ALUOUT and MDR, immediate extender, operand and write-back muxes
`timescale 1ns/1ps

module datapath #(
	parameter cpuPkg::word_t resetVector = 16'h0000
) (
	input logic Clock,
	input logic rstN,
	input cpuPkg::dpCtrl_t ctrl,
	input logic carryIn,
	input cpuPkg::word_t datIn,
	output cpuPkg::dpStat_t stat,
	output cpuPkg::word_t adr,
	output cpuPkg::word_t datOut
);

	cpuPkg::word_t pc, lr, ir, aluOut, mdr;
	cpuPkg::word_t pcIn, op1, op2, imm, wData;
	cpuPkg::word_t rd1, rd2, aluResult;
	cpuPkg::regIdx_t rs2Idx;
	cpuPkg::flags_t aluFlags;

	// sign extension of imm5 or imm8
	always_comb begin
		if (ctrl.immSel == cpuPkg::ImmShort) begin
			imm = {{11{ir[cpuPkg::Imm5Msb]}}, ir[cpuPkg::Imm5Msb:0]};
		end else begin
			imm = {{8{ir[cpuPkg::Imm8Msb]}}, ir[cpuPkg::Imm8Msb:0]};
		end
	end

	// rb overlaps imm5, so with an immediate operand port 2 reads rd (store data)
	assign rs2Idx = (ctrl.op2Sel == cpuPkg::Op2Rd2) ? ir[cpuPkg::RbLsb +: 3]
		: ir[cpuPkg::RdLsb +: 3];

	always_comb begin
		case (ctrl.op1Sel)
			cpuPkg::Op1Pc: op1 = pc;
			default: op1 = rd1;
		endcase
		case (ctrl.op2Sel)
			cpuPkg::Op2Imm: op2 = imm;
			cpuPkg::Op2One: op2 = 16'd1;
			default: op2 = rd2;
		endcase
	end

	always_comb begin
		case (ctrl.wdSel)
			cpuPkg::WdMem: wData = mdr;
			cpuPkg::WdLr: wData = lr;
			default: wData = aluOut;
		endcase
	end

	always_comb begin
		case (ctrl.pcSel)
			cpuPkg::PcAluOut: pcIn = aluOut;   // CALL target from decode
			cpuPkg::PcLr: pcIn = lr;
			cpuPkg::PcBranch: pcIn = aluResult; // pc + imm8 in exec
			default: pcIn = pc + 16'd1;
		endcase
	end

	regFile regs (
		.Clock (Clock),
		.rstN  (rstN),
		.rs1   (ir[cpuPkg::RaLsb +: 3]),
		.rs2   (rs2Idx),
		.rw    (ir[cpuPkg::RdLsb +: 3]),
		.wData (wData),
		.we    (ctrl.regWe),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	alu alu (
		.op1     (op1),
		.op2     (op2),
		.carryIn (carryIn),
		.aluOp   (ctrl.aluOp),
		.result  (aluResult),
		.flags   (aluFlags)
	);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pc <= resetVector;
			ir <= '0;
		end else begin
			if (ctrl.pcWe) begin
				pc <= pcIn;
			end
			if (ctrl.irWe) begin
				ir <= datIn; // fetch ack
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.lrWe) begin
			lr <= pc; // already incremented at fetch
		end
		if (ctrl.aluWe) begin
			aluOut <= aluResult;
		end
		if (ctrl.mdrWe) begin
			mdr <= datIn; // load ack
		end
	end

	assign adr = (ctrl.adrSel == cpuPkg::AdrAluOut) ? aluOut : pc;
	assign datOut = rd2;
	assign stat = '{opcode: cpuPkg::opcode_t'(ir[cpuPkg::OpcodeLsb +: 5]), aluFlags: aluFlags};

endmodule

/* hw/controlSequencer.sv */
// control FSM with opcode decode, flags register, datapath controls and Wishbone cycle control
`timescale 1ns/1ps

module controlSequencer (
	input logic Clock,
	input logic rstN,
	input cpuPkg::dpStat_t stat,
	input logic ack,
	output cpuPkg::dpCtrl_t ctrl,
	output logic carryOut,
	output logic cyc,
	output logic stb,
	output logic we,
	output logic halted
);

	cpuPkg::seqState_t state, nextState;
	cpuPkg::flags_t flagsReg;
	logic flagsWe;
	logic busGap;    // one idle cycle after reset and after every ack
	logic busActive;
	logic busDone;

	assign busActive = !busGap && ((state == cpuPkg::SFetch) || (state == cpuPkg::SMem));
	assign busDone = busActive && ack;

	always_comb begin
		ctrl.aluOp = cpuPkg::AluAdd;
		ctrl.op1Sel = cpuPkg::Op1Rd1;
		ctrl.op2Sel = cpuPkg::Op2Rd2;
		ctrl.immSel = cpuPkg::ImmShort;
		ctrl.wdSel = cpuPkg::WdAlu;
		ctrl.pcSel = cpuPkg::PcInc;
		ctrl.adrSel = cpuPkg::AdrPc;
		ctrl.pcWe = 1'b0;
		ctrl.lrWe = 1'b0;
		ctrl.irWe = 1'b0;
		ctrl.aluWe = 1'b0;
		ctrl.mdrWe = 1'b0;
		ctrl.regWe = 1'b0;
		flagsWe = 1'b0;
		nextState = state;
		case (state)
			cpuPkg::SFetch: begin
				if (busDone) begin
					ctrl.irWe = 1'b1;
					ctrl.pcWe = 1'b1; // pc + 1
					nextState = cpuPkg::SDecode;
				end
			end
			cpuPkg::SDecode: begin
				// IR valid from here, precompute pc + imm8 for CALL
				ctrl.op1Sel = cpuPkg::Op1Pc;
				ctrl.op2Sel = cpuPkg::Op2Imm;
				ctrl.immSel = cpuPkg::ImmLong;
				ctrl.aluWe = 1'b1;
				nextState = cpuPkg::SExec;
			end
			cpuPkg::SExec: begin
				case (stat.opcode)
					cpuPkg::OpAdd, cpuPkg::OpAdc, cpuPkg::OpSub,
					cpuPkg::OpAnd, cpuPkg::OpOr, cpuPkg::OpXor: begin
						case (stat.opcode)
							cpuPkg::OpAdc: ctrl.aluOp = cpuPkg::AluAdc;
							cpuPkg::OpSub: ctrl.aluOp = cpuPkg::AluSub;
							cpuPkg::OpAnd: ctrl.aluOp = cpuPkg::AluAnd;
							cpuPkg::OpOr: ctrl.aluOp = cpuPkg::AluOr;
							cpuPkg::OpXor: ctrl.aluOp = cpuPkg::AluXor;
							default: ctrl.aluOp = cpuPkg::AluAdd;
						endcase
						ctrl.aluWe = 1'b1;
						flagsWe = 1'b1;
						nextState = cpuPkg::SWrite;
					end
					cpuPkg::OpAddi: begin
						ctrl.op2Sel = cpuPkg::Op2Imm;
						ctrl.aluWe = 1'b1;
						flagsWe = 1'b1;
						nextState = cpuPkg::SWrite;
					end
					cpuPkg::OpMovi: begin
						ctrl.aluOp = cpuPkg::AluPassB;
						ctrl.op2Sel = cpuPkg::Op2Imm;
						ctrl.immSel = cpuPkg::ImmLong;
						ctrl.aluWe = 1'b1;
						flagsWe = 1'b1;
						nextState = cpuPkg::SWrite;
					end
					cpuPkg::OpLdw, cpuPkg::OpStw: begin
						ctrl.op2Sel = cpuPkg::Op2Imm; // ra + imm5 into ALUOUT
						ctrl.aluWe = 1'b1;
						nextState = cpuPkg::SMem;
					end
					cpuPkg::OpBz: begin
						ctrl.op1Sel = cpuPkg::Op1Pc;
						ctrl.op2Sel = cpuPkg::Op2Imm;
						ctrl.immSel = cpuPkg::ImmLong;
						ctrl.pcSel = cpuPkg::PcBranch;
						ctrl.pcWe = flagsReg[cpuPkg::FlagZ];
						nextState = cpuPkg::SFetch;
					end
					cpuPkg::OpCall: begin
						ctrl.pcSel = cpuPkg::PcAluOut;
						ctrl.pcWe = 1'b1;
						ctrl.lrWe = 1'b1;
						nextState = cpuPkg::SFetch;
					end
					cpuPkg::OpRet: begin
						ctrl.pcSel = cpuPkg::PcLr;
						ctrl.pcWe = 1'b1;
						nextState = cpuPkg::SFetch;
					end
					cpuPkg::OpHalt: nextState = cpuPkg::SHalt;
					default: nextState = cpuPkg::SFetch; // unused codes act as nop
				endcase
			end
			cpuPkg::SMem: begin
				ctrl.adrSel = cpuPkg::AdrAluOut;
				ctrl.op2Sel = cpuPkg::Op2Imm; // keeps rd on datOut
				if (busDone) begin
					if (stat.opcode == cpuPkg::OpLdw) begin
						ctrl.mdrWe = 1'b1;
						nextState = cpuPkg::SWrite;
					end else begin
						nextState = cpuPkg::SFetch;
					end
				end
			end
			cpuPkg::SWrite: begin
				if (stat.opcode == cpuPkg::OpLdw) begin
					ctrl.wdSel = cpuPkg::WdMem;
				end
				ctrl.regWe = 1'b1;
				nextState = cpuPkg::SFetch;
			end
			cpuPkg::SHalt: nextState = cpuPkg::SHalt; // until reset
			default: nextState = cpuPkg::SFetch;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= cpuPkg::SFetch;
			flagsReg <= '0;
			busGap <= 1'b1;
		end else begin
			state <= nextState;
			busGap <= busDone;
			if (flagsWe) begin
				flagsReg <= stat.aluFlags;
			end
		end
	end

	assign cyc = busActive;
	assign stb = busActive;
	assign we = busActive && (state == cpuPkg::SMem) && (stat.opcode == cpuPkg::OpStw);
	assign carryOut = flagsReg[cpuPkg::FlagC]; // feeds ADC
	assign halted = (state == cpuPkg::SHalt);

endmodule

/* hw/cpuTop.sv */
// core top level joining sequencer and datapath onto one Wishbone master port
`timescale 1ns/1ps

module cpuTop #(
	parameter cpuPkg::word_t resetVector = 16'h0000
) (
	input logic Clock,
	input logic rstN,
	output cpuPkg::wbReq_t wb,
	input cpuPkg::wbRsp_t wbRsp,
	output logic halted
);

	cpuPkg::dpCtrl_t ctrl;
	cpuPkg::dpStat_t stat;
	logic carry;
	logic cyc;
	logic stb;
	logic we;
	cpuPkg::word_t adr;
	cpuPkg::word_t datOut;

	controlSequencer sequencer (
		.Clock    (Clock),
		.rstN     (rstN),
		.stat     (stat),
		.ack      (wbRsp.ack),
		.ctrl     (ctrl),
		.carryOut (carry),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.halted   (halted)
	);

	datapath #(
		.resetVector (resetVector)
	) dp (
		.Clock   (Clock),
		.rstN    (rstN),
		.ctrl    (ctrl),
		.carryIn (carry),
		.datIn   (wbRsp.datIn),
		.stat    (stat),
		.adr     (adr),
		.datOut  (datOut)
	);

	// cycle control from the sequencer, address and data from the datapath
	assign wb = '{cyc: cyc, stb: stb, we: we, adr: adr, datOut: datOut};

endmodule

/* include/tbIsaModel.svh */
// testbench ISA model, random program generator, memory arrays and expected bus trace
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int MemWords = 128;
localparam int DataBase = 'h60;         // r7 holds this, data region is 0x50..0x6f
localparam int BodyLen = 24;
localparam int BodyEnd = 1 + BodyLen;   // first of the eight closing stores
localparam int SubAddr = BodyEnd + 9;   // subroutine sits after the halt
localparam int MaxSteps = 64;

typedef struct packed {
	logic we;
	cpuPkg::word_t adr;
	cpuPkg::word_t dat;
} busAcc_t;

cpuPkg::word_t mem [0:MemWords-1];    // slave memory, changed by DUT stores
cpuPkg::word_t refMem [0:MemWords-1]; // model copy
busAcc_t expQ [$];                    // every bus access the model expects, in order

function automatic int randBelow(int n);
	return int'({$random(seed)} % n);
endfunction

function automatic cpuPkg::word_t encode(logic [4:0] op, int rd, int ra, int low5);
	return {op, rd[2:0], ra[2:0], low5[4:0]};
endfunction

function automatic cpuPkg::word_t encodeLong(logic [4:0] op, int rd, int imm8);
	return {op, rd[2:0], imm8[7:0]};
endfunction

// register op or ADDI, never touching r0 or the base in r7
task automatic emitAluOp(input int at);
	if (randBelow(2) == 0) begin
		mem[at] = encode(5'(cpuPkg::OpAdd) + 5'(randBelow(6)), 1 + randBelow(6),
			randBelow(8), randBelow(8) * 4);
	end else begin
		mem[at] = encode(cpuPkg::OpAddi, 1 + randBelow(6), randBelow(8), randBelow(32));
	end
endtask

// mode 0 arithmetic, 1 load and store, 2 branch and call, 3 mixed
task automatic buildProgram(input int mode);
	int pc;
	int cat;
	int calls;
	int off;
	int rx;
	for (int a = 0; a < MemWords; a++) begin
		mem[a] = {~a[7:0], a[7:0]};
	end
	for (int a = 'h50; a < 'h70; a++) begin
		mem[a] = 16'($random(seed));
	end
	mem[0] = encodeLong(cpuPkg::OpMovi, 7, DataBase);
	pc = 1;
	calls = 0;
	while (pc < BodyEnd) begin
		cat = randBelow(6);
		case (mode)
			0: cat = cat % 3;
			1: cat = (cat < 4) ? 3 : 2;
			2: cat = (cat < 2) ? 0 : ((cat == 3) ? 4 : cat);
			default: ;
		endcase
		case (cat)
			0, 1: emitAluOp(pc);
			2: mem[pc] = encodeLong(cpuPkg::OpMovi, 1 + randBelow(6), randBelow(256));
			3: begin
				if (pc + 1 < BodyEnd) begin
					rx = 1 + randBelow(6); // copy one data word
					mem[pc] = encode(cpuPkg::OpLdw, rx, 7, randBelow(32));
					pc++;
					mem[pc] = encode(cpuPkg::OpStw, rx, 7, randBelow(32));
				end else begin
					emitAluOp(pc);
				end
			end
			4: begin
				off = randBelow(4); // forward only
				if (pc + 1 + off > BodyEnd) begin
					off = BodyEnd - pc - 1;
				end
				mem[pc] = encodeLong(cpuPkg::OpBz, 0, off);
			end
			default: begin
				if (calls < 3) begin
					mem[pc] = encodeLong(cpuPkg::OpCall, 0, SubAddr - pc - 1);
					calls++;
				end else begin
					emitAluOp(pc);
				end
			end
		endcase
		pc++;
	end
	for (int i = 0; i < 8; i++) begin
		mem[BodyEnd + i] = encode(cpuPkg::OpStw, i, 7, i - 8); // dump r0..r7
	end
	mem[BodyEnd + 8] = encode(cpuPkg::OpHalt, 0, 0, 0);
	for (int i = 0; i < 4; i++) begin
		emitAluOp(SubAddr + i);
	end
	mem[SubAddr + 4] = encode(cpuPkg::OpRet, 0, 0, 0);
endtask

task automatic expectAccess(input logic we, input cpuPkg::word_t adr, input cpuPkg::word_t dat);
	busAcc_t acc;
	acc.we = we;
	acc.adr = adr;
	acc.dat = dat;
	expQ.push_back(acc);
endtask

// runs the program on refMem and lists fetches, loads and stores
task automatic runModel();
	cpuPkg::word_t r [0:7];
	cpuPkg::word_t pc, lr, ir, a, b, ea, sext5, sext8;
	cpuPkg::opcode_t op;
	logic [16:0] s;
	logic fz, fc, done, aluWrite;
	int steps;
	refMem = mem;
	expQ.delete();
	for (int i = 0; i < 8; i++) begin
		r[i] = '0;
	end
	pc = 16'h0000;
	lr = 16'h0000;
	fz = 1'b0;
	fc = 1'b0;
	done = 1'b0;
	steps = 0;
	while (!done && steps < MaxSteps) begin
		ir = refMem[pc[6:0]];
		expectAccess(1'b0, pc, ir);
		pc = pc + 16'd1; // branch base is the next instruction
		op = cpuPkg::opcode_t'(ir[15:11]);
		a = r[ir[7:5]];
		b = r[ir[4:2]];
		sext5 = {{11{ir[4]}}, ir[4:0]};
		sext8 = {{8{ir[7]}}, ir[7:0]};
		ea = a + sext5;
		aluWrite = 1'b1;
		s = '0;
		case (op)
			cpuPkg::OpAdd: s = {1'b0, a} + {1'b0, b};
			cpuPkg::OpAdc: s = {1'b0, a} + {1'b0, b} + {16'd0, fc};
			cpuPkg::OpSub: s = {a >= b, a - b}; // carry is not-borrow
			cpuPkg::OpAnd: s = {1'b0, a & b};
			cpuPkg::OpOr: s = {1'b0, a | b};
			cpuPkg::OpXor: s = {1'b0, a ^ b};
			cpuPkg::OpAddi: s = {1'b0, a} + {1'b0, sext5};
			cpuPkg::OpMovi: s = {1'b0, sext8};
			default: aluWrite = 1'b0;
		endcase
		if (aluWrite) begin
			if (ir[10:8] != 3'd0) begin
				r[ir[10:8]] = s[15:0];
			end
			fz = (s[15:0] == 16'h0000);
			fc = s[16];
		end
		case (op)
			cpuPkg::OpLdw: begin
				expectAccess(1'b0, ea, refMem[ea[6:0]]);
				if (ir[10:8] != 3'd0) begin
					r[ir[10:8]] = refMem[ea[6:0]];
				end
			end
			cpuPkg::OpStw: begin
				refMem[ea[6:0]] = r[ir[10:8]];
				expectAccess(1'b1, ea, r[ir[10:8]]);
			end
			cpuPkg::OpBz: begin
				if (fz) begin
					pc = pc + sext8;
				end
			end
			cpuPkg::OpCall: begin
				lr = pc;
				pc = pc + sext8;
			end
			cpuPkg::OpRet: pc = lr;
			cpuPkg::OpHalt: done = 1'b1;
			default: ;
		endcase
		steps++;
	end
endtask

`endif

/* test/tbCpu.sv */
// testbench top with clock, reset, Wishbone slave with random wait states, checks and watchdog
`timescale 1ns/1ps

module tbCpu;

	localparam int NumTests = 4;
	localparam int ClockPeriod = 20;
	localparam cpuPkg::word_t ResetVector = 16'h0000;

	logic Clock;
	logic rstN;
	cpuPkg::wbReq_t wb;
	cpuPkg::wbRsp_t wbRsp = '0;
	logic halted;

	integer seed = 32'h34af35f2;
	int errors = 0;
	int passedTests = 0;

	// slave state
	logic pending = 1'b0;
	int waitLeft = 0;
	int resetEdges = 0;
	int accCount = 0;
	cpuPkg::wbReq_t heldReq;
	cpuPkg::word_t rdData;

	`include "tbIsaModel.svh"

	cpuTop #(
		.resetVector (ResetVector)
	) UUT (
		.Clock  (Clock),
		.rstN   (rstN),
		.wb     (wb),
		.wbRsp  (wbRsp),
		.halted (halted)
	);

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	initial begin
		#(NumTests * MaxSteps * 12 * ClockPeriod);
		$display("Watchdog timeout, the DUT did not halt in time");
		$display("Done: errors found");
		$finish;
	end

	function automatic string testName(int t);
		case (t)
			0: return "arithmetic";
			1: return "load and store";
			2: return "branch and call";
			default: return "mixed";
		endcase
	endfunction

	// compares one acked access with the model trace and applies it to memory
	task automatic serveAccess(output cpuPkg::word_t data);
		busAcc_t want;
		if (accCount == 0) begin
			assert (!wb.we && wb.adr == ResetVector) else begin
				$display("Fail first wb.adr exp %h got %h (we %h)", ResetVector, wb.adr, wb.we);
				errors++;
			end
		end
		accCount++;
		assert (expQ.size() > 0) else begin
			$display("Extra bus access to address %h beyond the program", wb.adr);
			errors++;
		end
		if (expQ.size() > 0) begin
			want = expQ.pop_front();
			assert (wb.we == want.we) else begin
				$display("Fail wb.we exp %h got %h at adr %h", want.we, wb.we, wb.adr);
				errors++;
			end
			assert (wb.adr == want.adr) else begin
				$display("Fail wb.adr exp %h got %h", want.adr, wb.adr);
				errors++;
			end
			assert (!wb.we || wb.datOut == want.dat) else begin
				$display("Fail wb.datOut exp %h got %h", want.dat, wb.datOut);
				errors++;
			end
		end
		if (wb.we) begin
			mem[wb.adr[6:0]] = wb.datOut;
		end
		data = mem[wb.adr[6:0]];
	endtask

	// Wishbone slave, registered ack after 0 to 3 wait cycles
	always @(posedge Clock) begin
		if (!rstN) begin
			assert (resetEdges == 0 || wb.cyc == 1'b0) else begin
				$display("Fail wb.cyc during reset exp 0 got %h", wb.cyc);
				errors++;
			end
			resetEdges++;
			pending = 1'b0;
			accCount = 0;
			wbRsp <= '0;
		end else begin
			resetEdges = 0;
			assert (wb.stb == wb.cyc) else begin
				$display("Fail wb.stb exp %h got %h", wb.cyc, wb.stb);
				errors++;
			end
			assert (!(halted && wb.cyc)) else begin
				$display("Bus cycle requested at address %h after halt", wb.adr);
				errors++;
			end
			if (wbRsp.ack) begin
				wbRsp.ack <= 1'b0; // master drops cyc now
			end else if (wb.cyc && wb.stb) begin
				if (!pending) begin
					pending = 1'b1;
					heldReq = wb;
					waitLeft = randBelow(4);
				end
				assert (wb.adr == heldReq.adr && wb.we == heldReq.we
					&& wb.datOut == heldReq.datOut) else begin
					$display("Fail wb request changed, adr %h->%h we %h->%h datOut %h->%h",
						heldReq.adr, wb.adr, heldReq.we, wb.we, heldReq.datOut, wb.datOut);
					errors++;
				end
				if (waitLeft == 0) begin
					serveAccess(rdData);
					wbRsp.datIn <= rdData;
					wbRsp.ack <= 1'b1;
					pending = 1'b0;
				end else begin
					waitLeft--;
				end
			end else begin
				assert (!pending) else begin
					$display("Request to address %h withdrawn before ack", heldReq.adr);
					errors++;
				end
				pending = 1'b0;
			end
		end
	end

	initial begin
		int errorsBefore;
		rstN = 1'b0;
		for (int t = 0; t < NumTests; t++) begin
			errorsBefore = errors;
			buildProgram(t);
			runModel();
			rstN <= 1'b0;
			repeat (2) @(posedge Clock);
			rstN <= 1'b1;
			while (!halted) @(posedge Clock);
			repeat (8) @(posedge Clock); // no bus activity allowed here
			assert (expQ.size() == 0) else begin
				$display("The DUT halted with %0d expected bus accesses missing", expQ.size());
				errors++;
			end
			for (int a = 0; a < MemWords; a++) begin
				assert (mem[a] == refMem[a]) else begin
					$display("Fail mem[%h] exp %h got %h", a[6:0], refMem[a], mem[a]);
					errors++;
				end
			end
			if (errors == errorsBefore) begin
				passedTests++;
			end
			$display("Test %0d %s: %0d errors", t, testName(t), errors - errorsBefore);
		end
		$display("Tests run %0d, passed %0d, errors %0d", NumTests, passedTests, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+include
hw/cpuPkg.sv
hw/regFile.sv
hw/alu.sv
hw/datapath.sv
hw/controlSequencer.sv
hw/cpuTop.sv
test/tbCpu.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbCpu
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = run.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the grep decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
